// ==== hw/burst_config.svh ====
/*
 * burst address generator configuration
 * widths, command FIFO depth and APB register map
 */
`ifndef BURST_CONFIG_SVH
`define BURST_CONFIG_SVH

// generated address and length field widths
`define BURST_ADDR_W 8
`define BURST_LEN_W 8

// command entries held between APB and the expander
`define BURST_FIFO_DEPTH 4

// APB address width and register offsets
// offsets are sized to the APB address width
`define BURST_APB_ADDR_W 4
`define BURST_REG_CMD 4'h0
`define BURST_REG_STATUS 4'h4

`endif

// ==== hw/burst_pkg.sv ====
/*
 * burst address generator package
 * vector types for addresses, lengths, FIFO level and APB data,
 * plus the expander state encoding
 */
`default_nettype none

`include "burst_config.svh"

package burst_pkg;

    // one generated address
    typedef logic [`BURST_ADDR_W-1:0] addr_t;

    // burst length field, L gives L+1 beats
    typedef logic [`BURST_LEN_W-1:0] len_t;

    // fill level, must reach the full depth
    typedef logic [$clog2(`BURST_FIFO_DEPTH+1)-1:0] level_t;

    // APB data word
    typedef logic [31:0] apb_data_t;

    // expander FSM
    typedef enum logic {
        exp_idle,
        exp_burst
    } exp_state_t;

endpackage

`default_nettype wire

// ==== hw/cmd_stream_if.sv ====
/*
 * command stream interface
 * valid/ready handshake carrying a burst base address and length
 */
`timescale 1ns/10ps
`default_nettype none

interface cmd_stream_if
    import burst_pkg::*;
();

    // handshake
    logic valid;
    logic ready;

    // payload, held while valid and not ready
    addr_t base;
    len_t len;

    // sender of commands
    modport producer (
        output valid,
        output base,
        output len,
        input ready
    );

    // receiver of commands
    modport consumer (
        input valid,
        input base,
        input len,
        output ready
    );

endinterface

`default_nettype wire

// ==== hw/apb_cmd_regs.sv ====
/*
 * APB command register block
 * a CMD write becomes a one-cycle push into the command FIFO,
 * STATUS reports fill level, empty and a sticky overflow flag
 */
`timescale 1ns/10ps
`default_nettype none

`include "burst_config.svh"

module apb_cmd_regs
    import burst_pkg::*;
(
    input wire logic clock,
    input wire logic rst_n,
    input wire logic psel,
    input wire logic penable,
    input wire logic pwrite,
    input wire logic [`BURST_APB_ADDR_W-1:0] paddr,
    input wire apb_data_t pwdata,
    output apb_data_t prdata,
    output logic pslverr,
    input wire level_t level,
    cmd_stream_if.producer cmd
);

    // access phase decode, zero wait states
    logic access;
    logic wr_access;
    logic rd_access;
    logic sel_cmd;
    logic sel_status;
    logic unmapped;

    // command refused by a full FIFO
    logic cmd_drop;

    // sticky overflow and the last pushed command
    logic overflow;
    addr_t last_base;
    len_t last_len;

    apb_data_t status_word;
    apb_data_t cmd_word;

    assign access = psel && penable;
    assign wr_access = access && pwrite;
    assign rd_access = access && !pwrite;

    assign sel_cmd = (paddr == `BURST_REG_CMD);
    assign sel_status = (paddr == `BURST_REG_STATUS);
    assign unmapped = !sel_cmd && !sel_status;

    // push request lives for the access phase only
    assign cmd.valid = wr_access && sel_cmd;
    // base in 15:8, len in 7:0
    assign cmd.base = pwdata[`BURST_LEN_W +: `BURST_ADDR_W];
    assign cmd.len = pwdata[`BURST_LEN_W-1:0];

    assign cmd_drop = cmd.valid && !cmd.ready;

    // error in the same access phase
    assign pslverr = access && (unmapped || cmd_drop);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            overflow <= 1'b0;
        end else if (cmd_drop) begin
            overflow <= 1'b1;
        end else if (wr_access && sel_status && pwdata[5]) begin
            // write one to clear
            overflow <= 1'b0;
        end
    end

    // readback copy of the last accepted command
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            last_base <= '0;
            last_len <= '0;
        end else if (cmd.valid && cmd.ready) begin
            last_base <= cmd.base;
            last_len <= cmd.len;
        end
    end

    // status word, level in 3:0, empty bit 4, overflow bit 5
    always_comb begin
        status_word = '0;
        status_word[$bits(level_t)-1:0] = level;
        status_word[4] = (level == '0);
        status_word[5] = overflow;
    end

    always_comb begin
        cmd_word = '0;
        cmd_word[`BURST_LEN_W +: `BURST_ADDR_W] = last_base;
        cmd_word[`BURST_LEN_W-1:0] = last_len;
    end

    // read mux, unmapped reads return zero
    always_comb begin
        prdata = '0;
        if (rd_access) begin
            if (sel_cmd) begin
                prdata = cmd_word;
            end else if (sel_status) begin
                prdata = status_word;
            end
        end
    end

    // push only in an access phase that followed a CMD write setup
    a_push_in_cmd_write : assert property (
        @(posedge clock) disable iff (!rst_n)
        cmd.valid |-> penable &&
            $past(psel && !penable && pwrite && (paddr == `BURST_REG_CMD))
    );

endmodule

`default_nettype wire

// ==== hw/cmd_fifo.sv ====
/*
 * command FIFO
 * circular buffer of burst commands with registered storage,
 * fill level reported back to the APB status register
 */
`timescale 1ns/10ps
`default_nettype none

`include "burst_config.svh"

module cmd_fifo
    import burst_pkg::*;
#(
    parameter int DEPTH = `BURST_FIFO_DEPTH
) (
    input wire logic clock,
    input wire logic rst_n,
    cmd_stream_if.consumer push_side,
    cmd_stream_if.producer pop_side,
    output level_t level
);

    // pointer needs at least one bit even for a single entry
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    addr_t base_mem [DEPTH];
    len_t len_mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic push;
    logic pop;

    assign push_side.ready = (count != CNT_W'(DEPTH));
    assign pop_side.valid = (count != '0);

    assign push = push_side.valid && push_side.ready;
    assign pop = pop_side.valid && pop_side.ready;

    // head entry straight from storage
    assign pop_side.base = base_mem[rd_ptr];
    assign pop_side.len = len_mem[rd_ptr];

    assign level = level_t'(count);

    always_ff @(posedge clock) begin
        if (push) begin
            base_mem[wr_ptr] <= push_side.base;
            len_mem[wr_ptr] <= push_side.len;
        end
    end

    // explicit wrap so any depth works
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // simultaneous push and pop keep the level
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_level_bound : assert property (
        @(posedge clock) disable iff (!rst_n)
        count <= CNT_W'(DEPTH)
    );

    // stalled head must not move
    a_pop_stable : assert property (
        @(posedge clock) disable iff (!rst_n)
        pop_side.valid && !pop_side.ready |=>
            pop_side.valid && $stable(pop_side.base) && $stable(pop_side.len)
    );

endmodule

`default_nettype wire

// ==== hw/burst_addr_expander.sv ====
/*
 * burst address expander
 * turns one base/length command into L+1 consecutive addresses
 * on a valid/ready port, last flag on the final beat
 */
`timescale 1ns/10ps
`default_nettype none

module burst_addr_expander
    import burst_pkg::*;
(
    input wire logic clock,
    input wire logic rst_n,
    cmd_stream_if.consumer cmd,
    output addr_t addr,
    output logic addr_valid,
    input wire logic addr_ready,
    output logic addr_last
);

    exp_state_t state;

    // current address and burst length
    addr_t addr_q;
    len_t len_q;
    // beats already sent in this burst
    len_t beat_cnt;

    logic cmd_take;
    logic beat_take;
    logic final_beat;

    assign final_beat = (state == exp_burst) && (beat_cnt == len_q);

    // take the next command when idle or as the final beat leaves
    assign cmd.ready = (state == exp_idle) || (final_beat && addr_ready);

    assign cmd_take = cmd.valid && cmd.ready;
    assign beat_take = addr_valid && addr_ready;

    assign addr = addr_q;
    assign addr_valid = (state == exp_burst);
    assign addr_last = final_beat;

    // FSM
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= exp_idle;
        end else begin
            case (state)
                exp_idle: begin
                    if (cmd_take) begin
                        state <= exp_burst;
                    end
                end
                exp_burst: begin
                    // back to back bursts stay here
                    if (final_beat && addr_ready && !cmd_take) begin
                        state <= exp_idle;
                    end
                end
                default: state <= exp_idle;
            endcase
        end
    end

    // beat counter
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (cmd_take) begin
            beat_cnt <= '0;
        end else if (beat_take && !final_beat) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // address and length, wraps modulo the address width
    always_ff @(posedge clock) begin
        if (cmd_take) begin
            addr_q <= cmd.base;
            len_q <= cmd.len;
        end else if (beat_take && !final_beat) begin
            addr_q <= addr_q + 1'b1;
        end
    end

    // stalled beat holds address, last and valid
    a_hold_on_stall : assert property (
        @(posedge clock) disable iff (!rst_n)
        addr_valid && !addr_ready |=>
            addr_valid && $stable(addr) && $stable(addr_last)
    );

endmodule

`default_nettype wire

// ==== hw/burst_addr_top.sv ====
/*
 * burst address generator top level
 * APB command registers feed a command FIFO,
 * the expander turns each command into an address stream
 */
`timescale 1ns/10ps
`default_nettype none

`include "burst_config.svh"

module burst_addr_top
    import burst_pkg::*;
(
    input wire logic clock,
    input wire logic rst_n,
    // APB, zero wait states
    input wire logic psel,
    input wire logic penable,
    input wire logic pwrite,
    input wire logic [`BURST_APB_ADDR_W-1:0] paddr,
    input wire apb_data_t pwdata,
    output apb_data_t prdata,
    output logic pslverr,
    // address stream
    output addr_t addr,
    output logic addr_valid,
    input wire logic addr_ready,
    output logic addr_last
);

    // regs to FIFO, FIFO to expander
    cmd_stream_if cmd_in ();
    cmd_stream_if cmd_out ();

    level_t fifo_level;

    apb_cmd_regs u_regs (
        .clock (clock),
        .rst_n (rst_n),
        .psel (psel),
        .penable (penable),
        .pwrite (pwrite),
        .paddr (paddr),
        .pwdata (pwdata),
        .prdata (prdata),
        .pslverr (pslverr),
        .level (fifo_level),
        .cmd (cmd_in.producer)
    );

    cmd_fifo #(
        .DEPTH (`BURST_FIFO_DEPTH)
    ) u_fifo (
        .clock (clock),
        .rst_n (rst_n),
        .push_side (cmd_in.consumer),
        .pop_side (cmd_out.producer),
        .level (fifo_level)
    );

    burst_addr_expander u_expander (
        .clock (clock),
        .rst_n (rst_n),
        .cmd (cmd_out.consumer),
        .addr (addr),
        .addr_valid (addr_valid),
        .addr_ready (addr_ready),
        .addr_last (addr_last)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_burst_addr.sv ====
/*
 * testbench for the burst address generator
 * APB command writes, reference address model, ready back-pressure,
 * concurrent checks on the address stream and the APB responses
 */
`timescale 1ns/10ps
`default_nettype none

`include "burst_config.svh"

module tb_burst_addr
    import burst_pkg::*;
();

    localparam int HALF_PERIOD = 4;
    localparam int MODEL_SIZE = 8192;
    localparam int WAIT_LIMIT = 4000;

    logic clock;
    logic rst_n;
    logic psel;
    logic penable;
    logic pwrite;
    logic [`BURST_APB_ADDR_W-1:0] paddr;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic pslverr;
    addr_t addr;
    logic addr_valid;
    logic addr_ready;
    logic addr_last;

    // addr_ready pattern, 0 low, 1 high, 2 random
    int ready_mode;

    // reference model, one entry per expected beat
    addr_t model_addr [MODEL_SIZE];
    logic model_last [MODEL_SIZE];
    int model_wr;
    int model_rd;
    addr_t head_addr;
    logic head_last;
    addr_t prev_addr;
    logic prev_last;

    // expectations for the APB access in flight
    logic chk_err;
    logic exp_err;
    logic chk_rd;
    apb_data_t exp_rd;
    logic idle_chk;
    logic gapless_chk;

    int addr_errs = 0;
    int apb_errs = 0;
    int stream_errs = 0;
    int tb_errs = 0;

    burst_addr_top u_dut (
        .clock (clock),
        .rst_n (rst_n),
        .psel (psel),
        .penable (penable),
        .pwrite (pwrite),
        .paddr (paddr),
        .pwdata (pwdata),
        .prdata (prdata),
        .pslverr (pslverr),
        .addr (addr),
        .addr_valid (addr_valid),
        .addr_ready (addr_ready),
        .addr_last (addr_last)
    );

    initial clock = 1'b0;
    always #HALF_PERIOD clock = ~clock;

    always @(posedge clock) begin
        #1;
        case (ready_mode)
            0: addr_ready = 1'b0;
            1: addr_ready = 1'b1;
            default: addr_ready = ($urandom % 4) != 0;
        endcase
    end

    assign head_addr = model_addr[model_rd];
    assign head_last = model_last[model_rd];

    // pop the model on each accepted beat, keep last cycle's outputs
    always @(posedge clock) begin
        prev_addr <= addr;
        prev_last <= addr_last;
        if (!rst_n) begin
            model_rd <= 0;
        end else if (addr_valid && addr_ready) begin
            model_rd <= model_rd + 1;
        end
    end

    a_beat_expected : assert property (@(posedge clock) disable iff (!rst_n)
        addr_valid && addr_ready |-> model_rd != model_wr)
    else begin
        stream_errs++;
        $display("Error: %0t an address beat came out with no command pending", $time);
    end

    a_beat_value : assert property (@(posedge clock) disable iff (!rst_n)
        addr_valid && addr_ready && model_rd != model_wr |->
            addr == head_addr && addr_last == head_last)
    else begin
        addr_errs++;
        $display("Error: %0t addr,addr_last expected %h,%b actual %h,%b", $time,
            $sampled(head_addr), $sampled(head_last), $sampled(addr), $sampled(addr_last));
    end

    // stalled beat keeps address and last flag
    a_stall_hold : assert property (@(posedge clock) disable iff (!rst_n)
        addr_valid && !addr_ready |=> addr == prev_addr && addr_last == prev_last)
    else begin
        addr_errs++;
        $display("Error: %0t addr,addr_last expected %h,%b actual %h,%b", $time,
            $sampled(prev_addr), $sampled(prev_last), $sampled(addr), $sampled(addr_last));
    end

    a_gapless : assert property (@(posedge clock) disable iff (!rst_n)
        gapless_chk && addr_valid && addr_ready && addr_last &&
            (model_wr - model_rd > 1) |=> addr_valid)
    else begin
        stream_errs++;
        $display("Error: %0t idle cycle between queued bursts", $time);
    end

    a_apb_err : assert property (@(posedge clock) disable iff (!rst_n)
        psel && penable && chk_err |-> pslverr == exp_err)
    else begin
        apb_errs++;
        $display("Error: %0t pslverr expected %b actual %b", $time,
            $sampled(exp_err), $sampled(pslverr));
    end

    a_apb_read : assert property (@(posedge clock) disable iff (!rst_n)
        psel && penable && !pwrite && chk_rd |-> prdata == exp_rd)
    else begin
        apb_errs++;
        $display("Error: %0t prdata expected %h actual %h", $time,
            $sampled(exp_rd), $sampled(prdata));
    end

    a_idle : assert property (@(posedge clock) disable iff (!rst_n)
        idle_chk |-> !addr_valid && !pslverr)
    else begin
        stream_errs++;
        $display("Error: %0t addr_valid,pslverr expected 0,0 actual %b,%b", $time,
            $sampled(addr_valid), $sampled(pslverr));
    end

    // setup phase, access phase, err sampled late in the access phase
    task automatic apb_write(input logic [3:0] offset, input apb_data_t data,
                             input logic check, input logic want_err, output logic err);
        psel = 1'b1;
        pwrite = 1'b1;
        paddr = offset;
        pwdata = data;
        chk_err = check;
        exp_err = want_err;
        @(posedge clock);
        #1;
        penable = 1'b1;
        #(2 * HALF_PERIOD - 2);
        err = pslverr;
        @(posedge clock);
        #1;
        psel = 1'b0;
        penable = 1'b0;
        chk_err = 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] offset, input apb_data_t want,
                            input logic want_err);
        psel = 1'b1;
        pwrite = 1'b0;
        paddr = offset;
        chk_rd = 1'b1;
        exp_rd = want;
        chk_err = 1'b1;
        exp_err = want_err;
        @(posedge clock);
        #1;
        penable = 1'b1;
        @(posedge clock);
        #1;
        psel = 1'b0;
        penable = 1'b0;
        chk_rd = 1'b0;
        chk_err = 1'b0;
    endtask

    // accepted commands expand into L+1 model entries
    task automatic push_cmd(input addr_t base, input len_t len, input logic check,
                            input logic want_err, output logic err);
        apb_write(`BURST_REG_CMD, {16'h0, base, len}, check, want_err, err);
        if (!err) begin
            for (int k = 0; k <= int'(len); k++) begin
                model_addr[model_wr] = base + addr_t'(k);
                model_last[model_wr] = (k == int'(len));
                model_wr++;
            end
        end
    endtask

    task automatic drain_model();
        int cycles;
        cycles = 0;
        while (model_rd != model_wr && cycles < WAIT_LIMIT) begin
            @(posedge clock);
            cycles++;
        end
        if (model_rd != model_wr) begin
            tb_errs++;
            $display("Timeout: %0d expected addresses never came out", model_wr - model_rd);
        end
        @(posedge clock);
        #1;
    endtask

    initial begin
        apb_data_t last_word;
        logic err;
        addr_t base;
        len_t len;
        void'($urandom(79));
        {psel, penable, pwrite, addr_ready, chk_err, exp_err, chk_rd} = '0;
        {idle_chk, gapless_chk} = '0;
        paddr = '0;
        pwdata = '0;
        exp_rd = '0;
        last_word = '0;
        ready_mode = 0;
        model_wr = 0;
        rst_n = 1'b0;
        repeat (4) @(posedge clock);
        #1;
        rst_n = 1'b1;

        // quiet after reset, level 0 and empty
        idle_chk = 1'b1;
        repeat (3) @(posedge clock);
        #1;
        idle_chk = 1'b0;
        apb_read(`BURST_REG_STATUS, 32'h10, 1'b0);

        // single beat, then a burst wrapping past 0xff
        ready_mode = 1;
        push_cmd(8'h10, 8'h00, 1'b1, 1'b0, err);
        push_cmd(8'hfc, 8'h0a, 1'b1, 1'b0, err);
        drain_model();

        // stalled output, one command in the expander and four queued
        ready_mode = 0;
        for (int i = 0; i < 5; i++) begin
            base = addr_t'($urandom);
            len = len_t'($urandom % 8);
            push_cmd(base, len, 1'b1, 1'b0, err);
            last_word = {16'h0, base, len};
        end
        push_cmd(8'h55, 8'h03, 1'b1, 1'b1, err);
        apb_read(`BURST_REG_STATUS, 32'h24, 1'b0);
        apb_read(`BURST_REG_CMD, last_word, 1'b0);
        apb_write(`BURST_REG_STATUS, 32'h20, 1'b1, 1'b0, err);
        apb_read(`BURST_REG_STATUS, 32'h04, 1'b0);
        apb_write(4'h8, 32'h1234, 1'b1, 1'b1, err);
        apb_read(4'hc, 32'h0, 1'b1);

        // release, queued bursts must follow back to back
        gapless_chk = 1'b1;
        ready_mode = 1;
        drain_model();
        gapless_chk = 1'b0;

        // random bursts under random back-pressure
        ready_mode = 2;
        for (int i = 0; i < 24; i++) begin
            base = addr_t'($urandom);
            len = ($urandom % 4 == 0) ? len_t'($urandom) : len_t'($urandom % 8);
            push_cmd(base, len, 1'b0, 1'b0, err);
            // random gap between commands
            repeat ($urandom % 4) begin
                @(posedge clock);
                #1;
            end
        end
        ready_mode = 1;
        drain_model();

        // clear any overflow from random traffic, expect empty again
        apb_write(`BURST_REG_STATUS, 32'h20, 1'b1, 1'b0, err);
        apb_read(`BURST_REG_STATUS, 32'h10, 1'b0);
        if (model_rd != model_wr) begin
            tb_errs++;
            $display("model queue still holds %0d addresses", model_wr - model_rd);
        end

        $display("errors: address %0d, apb %0d, stream %0d, testbench %0d",
            addr_errs, apb_errs, stream_errs, tb_errs);
        if (addr_errs + apb_errs + stream_errs + tb_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+hw
hw/burst_pkg.sv
hw/cmd_stream_if.sv
hw/apb_cmd_regs.sv
hw/cmd_fifo.sv
hw/burst_addr_expander.sv
hw/burst_addr_top.sv
testbench/tb_burst_addr.sv

// ==== run_sim.sh ====
#!/bin/sh
# build tb_burst_addr with Verilator, run it, verdict from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module tb_burst_addr \
    -f build.f -o tb_burst_addr > build.log 2>&1 \
    || { cat build.log; echo "compile failed"; exit 1; }
./obj_dir/tb_burst_addr > sim.log 2>&1
cat sim.log
grep -qF "*** TEST PASSED ***" sim.log && exit 0 || exit 1
